//--- sources.f
+incdir+bench
common/glb_pkg.sv
hdl/glb_config_port.sv
hdl/io_controller.sv
io_bank_interconnect/io_bank_interconnect.sv
hdl/glb_bank.sv
hdl/glb_top.sv
bench/glb_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the global buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module glb_tb \
    --Mdir obj_dir -o glb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/glb_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Some tests failed" sim.log || [ $sim_status -ne 0 ]; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
exit 0

//--- bench/glb_tb_tasks.svh
// cycle stepping, config handshake and CGRA drive tasks
// read-return collection and compare tasks
`ifndef GLB_TB_TASKS_SVH
`define GLB_TB_TASKS_SVH

// to the drive point of the next cycle
task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
    cyc++;
endtask

task automatic check_cfg_data(input string name, input logic [CFG_DATA_WIDTH-1:0] got,
        input logic [CFG_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
        report_failure($sformatf("Mismatch at %0t: %s is 0x%h, expected 0x%h",
            $time, name, got, exp));
    end
endtask

task automatic check_rd_data(input string name, input logic [DATA_WIDTH-1:0] got,
        input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
        report_failure($sformatf("Mismatch at %0t: %s is 0x%h, expected 0x%h",
            $time, name, got, exp));
    end
endtask

task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        report_failure($sformatf("Mismatch at %0t: %s is %b, expected %b",
            $time, name, got, exp));
    end
endtask

// four-phase handshake, read value taken while ack is high
task automatic cfg_handshake(input logic wr, input logic [CFG_FEATURE_WIDTH-1:0] feature,
        input logic [CFG_REG_WIDTH-1:0] reg_addr, input logic [CFG_DATA_WIDTH-1:0] data,
        output logic [CFG_DATA_WIDTH-1:0] rdata);
    int n;
    cfg_in = '{wr: wr, feature: feature, reg_addr: reg_addr, data: data};
    cfg_req = 1'b1;
    n = 0;
    while (!cfg_ack) begin
        next_cycle();
        n++;
        if (n > WAIT_TIMEOUT) begin
            report_failure("timeout waiting for cfg_ack to rise");
        end
    end
    rdata = cfg_rd_data;
    cfg_req = 1'b0;
    cfg_in = '0;
    n = 0;
    while (cfg_ack) begin
        next_cycle();
        n++;
        if (n > WAIT_TIMEOUT) begin
            report_failure("timeout waiting for cfg_ack to fall");
        end
    end
endtask

task automatic start_pulse();
    cgra_start_pulse = 1'b1;
    for (int j = 0; j < NUM_IO; j++) begin
        model_cnt[j] = '0;
    end
    next_cycle();
    cgra_start_pulse = 1'b0;
endtask

task automatic cgra_write(input int ch, input logic [GLB_ADDR_WIDTH-1:0] addr,
        input int count);
    logic [DATA_WIDTH-1:0]     d;
    logic [GLB_ADDR_WIDTH-1:0] a;
    logic [GLB_ADDR_WIDTH-1:0] eff;
    for (int i = 0; i < count; i++) begin
        d = DATA_WIDTH'($urandom);
        a = addr + GLB_ADDR_WIDTH'(i);
        cgra_in[ch] = '{wr_en: 1'b1, rd_en: 1'b0, addr: a, wr_data: d};
        // write lands only if this channel owns the group
        if (accept_request(ch, 1'b1, a, eff) && group_owner(eff) == ch) begin
            model_mem[eff] = d;
        end
        next_cycle();
    end
    cgra_in[ch] = '0;
endtask

// check a returned word against the oldest read in flight
task automatic collect_return(input int ch);
    logic [DATA_WIDTH-1:0] exp;
    if (rd_data_valid[ch]) begin
        if (exp_q.size() == 0) begin
            report_failure("rd_data_valid rose with no read in flight");
        end else begin
            if (cyc - issue_q[0] != RD_LATENCY) begin
                report_failure($sformatf("read data came %0d cycles after the request, not %0d",
                    cyc - issue_q[0], RD_LATENCY));
            end
            exp = exp_q[0];
            check_rd_data("rd_data", rd_data[ch], exp);
            exp_q.delete(0);
            issue_q.delete(0);
        end
    end else if (issue_q.size() > 0 && cyc - issue_q[0] >= RD_LATENCY) begin
        report_failure("rd_data_valid missing for an accepted read");
    end
endtask

task automatic cgra_read(input int ch, input logic [GLB_ADDR_WIDTH-1:0] addr,
        input int count);
    logic [GLB_ADDR_WIDTH-1:0] a;
    logic [GLB_ADDR_WIDTH-1:0] eff;
    int                        n;
    for (int i = 0; i < count; i++) begin
        a = addr + GLB_ADDR_WIDTH'(i);
        cgra_in[ch] = '{wr_en: 1'b0, rd_en: 1'b1, addr: a, wr_data: '0};
        if (accept_request(ch, 1'b0, a, eff)) begin
            // no enabled bank on the return chain gives zero
            exp_q.push_back(group_owner(eff) == ch ? model_mem[eff] : '0);
            issue_q.push_back(cyc);
        end
        next_cycle();
        collect_return(ch);
    end
    cgra_in[ch] = '0;
    n = 0;
    while (exp_q.size() > 0) begin
        next_cycle();
        collect_return(ch);
        n++;
        if (n > WAIT_TIMEOUT) begin
            report_failure("timeout waiting for rd_data_valid");
        end
    end
    // nothing more may come back
    repeat (RD_LATENCY) begin
        next_cycle();
        check_valid("rd_data_valid", rd_data_valid[ch], 1'b0);
    end
endtask

task automatic apply_step(input step_t s);
    logic [CFG_DATA_WIDTH-1:0] rdata;
    case (s.op)
        OP_CFG_WR: begin
            cfg_handshake(1'b1, s.feature, s.reg_addr, s.value, rdata);
            model_cfg_write(s.feature, s.reg_addr, s.value);
        end
        OP_CFG_RD: begin
            cfg_handshake(1'b0, s.feature, s.reg_addr, '0, rdata);
            check_cfg_data("cfg_rd_data", rdata, s.value);
        end
        OP_WR: cgra_write(int'(s.ch), s.addr, int'(s.count));
        OP_RD: cgra_read(int'(s.ch), s.addr, int'(s.count));
        OP_STALL: stall[s.ch] = s.value[0];
        OP_START: start_pulse();
        default: report_failure("unknown operation in the stimulus table");
    endcase
endtask

`endif

//--- bench/glb_tb.sv
// global buffer testbench top
// clock, reset, stimulus table, scoreboard model and step loop
module glb_tb;
    import glb_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_TIMEOUT = 50;
    localparam int RD_LATENCY = 2;
    localparam int RAND_SEED = 27;

    typedef enum logic [2:0] {
        OP_CFG_WR,
        OP_CFG_RD,
        OP_WR,
        OP_RD,
        OP_STALL,
        OP_START
    } op_e;

    typedef struct packed {
        op_e                          op;
        logic                         ch;
        logic [CFG_FEATURE_WIDTH-1:0] feature;
        logic [CFG_REG_WIDTH-1:0]     reg_addr;
        logic [GLB_ADDR_WIDTH-1:0]    addr;
        logic [CFG_DATA_WIDTH-1:0]    value;
        logic [8:0]                   count;
    } step_t;

    logic                      clk;
    logic                      reset;
    logic                      cgra_start_pulse;
    logic                      stall [NUM_IO];
    cgra_req_t                 cgra_in [NUM_IO];
    logic [DATA_WIDTH-1:0]     rd_data [NUM_IO];
    logic                      rd_data_valid [NUM_IO];
    logic                      cfg_req;
    cfg_req_t                  cfg_in;
    logic                      cfg_ack;
    logic [CFG_DATA_WIDTH-1:0] cfg_rd_data;

    // scoreboard model of the whole buffer
    logic [DATA_WIDTH-1:0]     model_mem [NUM_BANKS*BANK_DEPTH];
    io_ctrl_cfg_t              model_cfg [NUM_IO];
    logic [CFG_DATA_WIDTH-1:0] model_cnt [NUM_IO];
    logic [NUM_IO-2:0]         model_sel;

    // reads in flight, expected data and issue cycle
    logic [DATA_WIDTH-1:0]     exp_q [$];
    int                        issue_q [$];
    int                        cyc;
    step_t                     steps [$];

    glb_top dut0 (
        .clk              (clk),
        .reset            (reset),
        .cgra_start_pulse (cgra_start_pulse),
        .stall            (stall),
        .cgra_in          (cgra_in),
        .rd_data          (rd_data),
        .rd_data_valid    (rd_data_valid),
        .cfg_req          (cfg_req),
        .cfg_in           (cfg_in),
        .cfg_ack          (cfg_ack),
        .cfg_rd_data      (cfg_rd_data)
    );

    `include "glb_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    // channel that owns the bank group of this address
    function automatic int group_owner(input logic [GLB_ADDR_WIDTH-1:0] addr);
        int grp;
        int owner;
        grp = int'(addr[GLB_ADDR_WIDTH-1 -: BANK_SEL_WIDTH]) / BANKS_PER_IO;
        owner = 0;
        for (int j = 1; j <= grp; j++) begin
            if (model_sel[j-1]) begin
                owner = j;
            end
        end
        return owner;
    endfunction

    // controller gate: mode, word count and stall
    function automatic logic accept_request(input int ch, input logic is_wr,
            input logic [GLB_ADDR_WIDTH-1:0] addr, output logic [GLB_ADDR_WIDTH-1:0] eff);
        logic ok;
        ok = 1'b0;
        eff = addr;
        if (!stall[ch]) begin
            case (model_cfg[ch].mode)
                IO_INSTREAM, IO_OUTSTREAM: begin
                    if ((is_wr == (model_cfg[ch].mode == IO_INSTREAM))
                            && (model_cnt[ch] < model_cfg[ch].num_words)) begin
                        ok = 1'b1;
                        eff = model_cfg[ch].start_addr + model_cnt[ch][GLB_ADDR_WIDTH-1:0];
                        model_cnt[ch] = model_cnt[ch] + CFG_DATA_WIDTH'(1);
                    end
                end
                IO_SRAM: ok = 1'b1;
                default: ok = 1'b0;
            endcase
        end
        return ok;
    endfunction

    function automatic void model_cfg_write(input logic [CFG_FEATURE_WIDTH-1:0] feature,
            input logic [CFG_REG_WIDTH-1:0] reg_addr, input logic [CFG_DATA_WIDTH-1:0] data);
        if (feature == FEATURE_SWITCH && reg_addr == REG_SWITCH_SEL) begin
            model_sel = data[NUM_IO-2:0];
        end else if (int'(feature) < NUM_IO) begin
            case (reg_addr)
                REG_MODE: model_cfg[int'(feature)].mode = io_mode_e'(data[1:0]);
                REG_START_ADDR: model_cfg[int'(feature)].start_addr = data[GLB_ADDR_WIDTH-1:0];
                REG_NUM_WORDS: model_cfg[int'(feature)].num_words = data;
                default: ;
            endcase
        end
    endfunction

    function automatic step_t make_step(input op_e op, input int target, input int reg_addr,
            input int addr, input int value, input int count);
        step_t s;
        s.op = op;
        s.ch = target[0];
        s.feature = CFG_FEATURE_WIDTH'(target);
        s.reg_addr = CFG_REG_WIDTH'(reg_addr);
        s.addr = GLB_ADDR_WIDTH'(addr);
        s.value = CFG_DATA_WIDTH'(value);
        s.count = 9'(count);
        return s;
    endfunction

    // op, channel or feature, register, address, value or expected, count
    function automatic void load_steps();
        // sram mode and a full memory fill through channel 0
        steps.push_back(make_step(OP_CFG_WR, 0, REG_MODE, 0, IO_SRAM, 0));
        steps.push_back(make_step(OP_CFG_WR, FEATURE_SWITCH, REG_SWITCH_SEL, 0, 0, 0));
        steps.push_back(make_step(OP_WR, 0, 0, 'h00, 0, 256));
        // configuration and readback
        steps.push_back(make_step(OP_CFG_WR, 0, REG_START_ADDR, 0, 'h10, 0));
        steps.push_back(make_step(OP_CFG_WR, 0, REG_NUM_WORDS, 0, 4, 0));
        steps.push_back(make_step(OP_CFG_WR, 1, REG_MODE, 0, IO_INSTREAM, 0));
        steps.push_back(make_step(OP_CFG_WR, 1, REG_START_ADDR, 0, 'h85, 0));
        steps.push_back(make_step(OP_CFG_WR, 1, REG_NUM_WORDS, 0, 3, 0));
        steps.push_back(make_step(OP_CFG_WR, FEATURE_SWITCH, REG_SWITCH_SEL, 0, 1, 0));
        steps.push_back(make_step(OP_CFG_RD, 0, REG_MODE, 0, IO_SRAM, 0));
        steps.push_back(make_step(OP_CFG_RD, 0, REG_START_ADDR, 0, 'h10, 0));
        steps.push_back(make_step(OP_CFG_RD, 0, REG_NUM_WORDS, 0, 4, 0));
        steps.push_back(make_step(OP_CFG_RD, 1, REG_MODE, 0, IO_INSTREAM, 0));
        steps.push_back(make_step(OP_CFG_RD, 1, REG_START_ADDR, 0, 'h85, 0));
        steps.push_back(make_step(OP_CFG_RD, 1, REG_NUM_WORDS, 0, 3, 0));
        steps.push_back(make_step(OP_CFG_RD, FEATURE_SWITCH, REG_SWITCH_SEL, 0, 1, 0));
        steps.push_back(make_step(OP_CFG_RD, 0, 3, 0, 0, 0));
        steps.push_back(make_step(OP_CFG_RD, FEATURE_SWITCH, 1, 0, 0, 0));
        steps.push_back(make_step(OP_CFG_RD, 5, 0, 0, 0, 0));
        // instream burst with two writes past num_words
        steps.push_back(make_step(OP_CFG_WR, 0, REG_MODE, 0, IO_INSTREAM, 0));
        steps.push_back(make_step(OP_START, 0, 0, 0, 0, 0));
        steps.push_back(make_step(OP_WR, 0, 0, 'h00, 0, 6));
        steps.push_back(make_step(OP_CFG_WR, 0, REG_MODE, 0, IO_SRAM, 0));
        steps.push_back(make_step(OP_RD, 0, 0, 'h10, 0, 6));
        steps.push_back(make_step(OP_RD, 0, 0, 'h3f, 0, 1));
        // switch at 1, channel 0 loses banks 2 and 3
        steps.push_back(make_step(OP_WR, 0, 0, 'h90, 0, 2));
        steps.push_back(make_step(OP_RD, 0, 0, 'h90, 0, 1));
        steps.push_back(make_step(OP_START, 0, 0, 0, 0, 0));
        steps.push_back(make_step(OP_WR, 1, 0, 'h00, 0, 3));
        steps.push_back(make_step(OP_CFG_WR, 1, REG_MODE, 0, IO_SRAM, 0));
        steps.push_back(make_step(OP_RD, 1, 0, 'hc4, 0, 2));
        steps.push_back(make_step(OP_RD, 1, 0, 'h10, 0, 1));
        steps.push_back(make_step(OP_CFG_WR, FEATURE_SWITCH, REG_SWITCH_SEL, 0, 0, 0));
        steps.push_back(make_step(OP_RD, 0, 0, 'h90, 0, 2));
        steps.push_back(make_step(OP_RD, 0, 0, 'h84, 0, 5));
        // stalled requests are dropped
        steps.push_back(make_step(OP_STALL, 0, 0, 0, 1, 0));
        steps.push_back(make_step(OP_WR, 0, 0, 'h20, 0, 2));
        steps.push_back(make_step(OP_RD, 0, 0, 'h20, 0, 1));
        steps.push_back(make_step(OP_STALL, 0, 0, 0, 0, 0));
        steps.push_back(make_step(OP_RD, 0, 0, 'h20, 0, 2));
        // stall inside a stream, then restart
        steps.push_back(make_step(OP_CFG_WR, 0, REG_START_ADDR, 0, 'h30, 0));
        steps.push_back(make_step(OP_CFG_WR, 0, REG_NUM_WORDS, 0, 2, 0));
        steps.push_back(make_step(OP_CFG_WR, 0, REG_MODE, 0, IO_INSTREAM, 0));
        steps.push_back(make_step(OP_START, 0, 0, 0, 0, 0));
        steps.push_back(make_step(OP_STALL, 0, 0, 0, 1, 0));
        steps.push_back(make_step(OP_WR, 0, 0, 'h00, 0, 2));
        steps.push_back(make_step(OP_STALL, 0, 0, 0, 0, 0));
        steps.push_back(make_step(OP_WR, 0, 0, 'h00, 0, 3));
        steps.push_back(make_step(OP_START, 0, 0, 0, 0, 0));
        steps.push_back(make_step(OP_WR, 0, 0, 'h00, 0, 1));
        steps.push_back(make_step(OP_CFG_WR, 0, REG_MODE, 0, IO_SRAM, 0));
        steps.push_back(make_step(OP_RD, 0, 0, 'h2f, 0, 4));
    endfunction

    initial begin
        void'($urandom(RAND_SEED));
        reset = 1'b1;
        cgra_start_pulse = 1'b0;
        cfg_req = 1'b0;
        cfg_in = '0;
        cyc = 0;
        model_sel = '0;
        for (int j = 0; j < NUM_IO; j++) begin
            stall[j] = 1'b0;
            cgra_in[j] = '0;
            model_cfg[j] = '{mode: IO_IDLE, start_addr: '0, num_words: '0};
            model_cnt[j] = '0;
        end
        load_steps();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_valid("cfg_ack", cfg_ack, 1'b0);
        check_valid("rd_data_valid[0]", rd_data_valid[0], 1'b0);
        check_valid("rd_data_valid[1]", rd_data_valid[1], 1'b0);
        for (int i = 0; i < steps.size(); i++) begin
            apply_step(steps[i]);
        end
        next_cycle();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- hdl/glb_top.sv
// global buffer top: config port, channel controllers, interconnect, banks
module glb_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               cgra_start_pulse,
    input  logic                               stall [glb_pkg::NUM_IO],
    input  glb_pkg::cgra_req_t                 cgra_in [glb_pkg::NUM_IO],
    output logic [glb_pkg::DATA_WIDTH-1:0]     rd_data [glb_pkg::NUM_IO],
    output logic                               rd_data_valid [glb_pkg::NUM_IO],
    input  logic                               cfg_req,
    input  glb_pkg::cfg_req_t                  cfg_in,
    output logic                               cfg_ack,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0] cfg_rd_data
);
    import glb_pkg::*;

    logic                      cfg_access;
    cfg_req_t                  cfg_int;
    logic [CFG_DATA_WIDTH-1:0] reg_rd_data;
    io_ctrl_cfg_t              io_cfg [NUM_IO];
    bank_req_t                 io_req [NUM_IO];
    logic [DATA_WIDTH-1:0]     io_rd_data [NUM_IO];
    bank_req_t                 bank_req [NUM_BANKS];
    logic [DATA_WIDTH-1:0]     bank_rd_data [NUM_BANKS];

    glb_config_port u_cfg_port (
        .clk         (clk),
        .reset       (reset),
        .cfg_req     (cfg_req),
        .cfg_in      (cfg_in),
        .cfg_ack     (cfg_ack),
        .cfg_rd_data (cfg_rd_data),
        .cfg_access  (cfg_access),
        .cfg_out     (cfg_int),
        .reg_rd_data (reg_rd_data)
    );

    for (genvar j = 0; j < NUM_IO; j++) begin : g_io
        io_controller u_io_ctrl (
            .clk              (clk),
            .reset            (reset),
            .cgra_start_pulse (cgra_start_pulse),
            .stall            (stall[j]),
            .cfg              (io_cfg[j]),
            .cgra_in          (cgra_in[j]),
            .rd_data          (rd_data[j]),
            .rd_data_valid    (rd_data_valid[j]),
            .bank_out         (io_req[j]),
            .bank_rd_data     (io_rd_data[j])
        );
    end

    io_bank_interconnect u_interconnect (
        .clk          (clk),
        .reset        (reset),
        .cfg_access   (cfg_access),
        .cfg_in       (cfg_int),
        .cfg_rd_data  (reg_rd_data),
        .io_cfg       (io_cfg),
        .io_req       (io_req),
        .io_rd_data   (io_rd_data),
        .bank_req     (bank_req),
        .bank_rd_data (bank_rd_data)
    );

    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        glb_bank u_bank (
            .clk     (clk),
            .reset   (reset),
            .req     (bank_req[k]),
            .rd_data (bank_rd_data[k])
        );
    end

endmodule

//--- hdl/glb_bank.sv
// single-port memory bank with registered read
module glb_bank (
    input  logic                           clk,
    input  logic                           reset,
    input  glb_pkg::bank_req_t             req,
    output logic [glb_pkg::DATA_WIDTH-1:0] rd_data
);
    import glb_pkg::*;

    logic [DATA_WIDTH-1:0]      mem [BANK_DEPTH];
    logic [BANK_ADDR_WIDTH-1:0] local_addr;

    // upper select bits are already decoded by the interconnect
    assign local_addr = req.addr[BANK_ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (req.wr_en) begin
            mem[local_addr] <= req.data;
        end
    end

    // output holds between reads
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data <= '0;
        end else if (req.rd_en) begin
            rd_data <= mem[local_addr];
        end
    end

    // the interconnect never drives both on one bank
    bank_no_collision: assert property (@(posedge clk) disable iff (reset)
        !(req.wr_en && req.rd_en));

endmodule

//--- io_bank_interconnect/io_bank_interconnect.sv
// configuration registers, channel chain switch and bank routing
// registered read-return chain back to the channels
module io_bank_interconnect (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               cfg_access,
    input  glb_pkg::cfg_req_t                  cfg_in,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0] cfg_rd_data,
    output glb_pkg::io_ctrl_cfg_t              io_cfg [glb_pkg::NUM_IO],
    input  glb_pkg::bank_req_t                 io_req [glb_pkg::NUM_IO],
    output logic [glb_pkg::DATA_WIDTH-1:0]     io_rd_data [glb_pkg::NUM_IO],
    output glb_pkg::bank_req_t                 bank_req [glb_pkg::NUM_BANKS],
    input  logic [glb_pkg::DATA_WIDTH-1:0]     bank_rd_data [glb_pkg::NUM_BANKS]
);
    import glb_pkg::*;

    logic [NUM_IO-2:0]         switch_sel;
    bank_req_t                 chain_req [NUM_IO];
    logic [NUM_BANKS-1:0]      bank_wr_en;
    logic [NUM_BANKS-1:0]      bank_rd_en;
    logic [NUM_BANKS-1:0]      rd_en_d1;
    logic [NUM_BANKS-1:0]      rd_en_d2;
    logic [DATA_WIDTH-1:0]     bank_data_q [NUM_BANKS];
    logic [DATA_WIDTH-1:0]     ret_chain [NUM_BANKS];

    // register writes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            switch_sel <= '0;
            for (int j = 0; j < NUM_IO; j++) begin
                io_cfg[j] <= '{mode: IO_IDLE, start_addr: '0, num_words: '0};
            end
        end else if (cfg_access && cfg_in.wr) begin
            if (cfg_in.feature == FEATURE_SWITCH && cfg_in.reg_addr == REG_SWITCH_SEL) begin
                switch_sel <= cfg_in.data[NUM_IO-2:0];
            end
            for (int j = 0; j < NUM_IO; j++) begin
                if (cfg_in.feature == CFG_FEATURE_WIDTH'(j)) begin
                    case (cfg_in.reg_addr)
                        REG_MODE: io_cfg[j].mode <= io_mode_e'(cfg_in.data[1:0]);
                        REG_START_ADDR: io_cfg[j].start_addr <= cfg_in.data[GLB_ADDR_WIDTH-1:0];
                        REG_NUM_WORDS: io_cfg[j].num_words <= cfg_in.data;
                        default: ;
                    endcase
                end
            end
        end
    end

    // readback, unmapped registers give 0
    always_comb begin
        cfg_rd_data = '0;
        if (cfg_access && !cfg_in.wr) begin
            if (cfg_in.feature == FEATURE_SWITCH && cfg_in.reg_addr == REG_SWITCH_SEL) begin
                cfg_rd_data = CFG_DATA_WIDTH'(switch_sel);
            end
            for (int j = 0; j < NUM_IO; j++) begin
                if (cfg_in.feature == CFG_FEATURE_WIDTH'(j)) begin
                    case (cfg_in.reg_addr)
                        REG_MODE: cfg_rd_data = CFG_DATA_WIDTH'(io_cfg[j].mode);
                        REG_START_ADDR: cfg_rd_data = CFG_DATA_WIDTH'(io_cfg[j].start_addr);
                        REG_NUM_WORDS: cfg_rd_data = io_cfg[j].num_words;
                        default: cfg_rd_data = '0;
                    endcase
                end
            end
        end
    end

    // channel chain: a group either takes its own channel or the one below
    assign chain_req[0] = io_req[0];
    for (genvar j = 1; j < NUM_IO; j++) begin : g_chain
        assign chain_req[j] = switch_sel[j-1] ? io_req[j] : chain_req[j-1];
    end

    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        localparam int GRP = k / BANKS_PER_IO;
        logic hit;

        assign hit = (chain_req[GRP].addr[GLB_ADDR_WIDTH-1 -: BANK_SEL_WIDTH]
                      == BANK_SEL_WIDTH'(k));
        assign bank_wr_en[k] = chain_req[GRP].wr_en && hit;
        assign bank_rd_en[k] = chain_req[GRP].rd_en && hit;
        assign bank_req[k] = '{
            wr_en: bank_wr_en[k],
            rd_en: bank_rd_en[k],
            addr:  {BANK_SEL_WIDTH'(0), chain_req[GRP].addr[BANK_ADDR_WIDTH-1:0]},
            data:  chain_req[GRP].data
        };

        always_ff @(posedge clk) begin
            bank_data_q[k] <= bank_rd_data[k];
        end

        // return chain runs high to low, enabled bank wins
        if (k == NUM_BANKS - 1) begin : g_top
            assign ret_chain[k] = rd_en_d2[k] ? bank_data_q[k] : '0;
        end else begin : g_mid
            assign ret_chain[k] = rd_en_d2[k] ? bank_data_q[k] : ret_chain[k+1];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_en_d1 <= '0;
            rd_en_d2 <= '0;
        end else begin
            rd_en_d1 <= bank_rd_en;
            rd_en_d2 <= rd_en_d1;
        end
    end

    for (genvar j = 0; j < NUM_IO; j++) begin : g_ret
        assign io_rd_data[j] = ret_chain[j*BANKS_PER_IO];

        one_rd_per_group: assert property (@(posedge clk) disable iff (reset)
            $onehot0(bank_rd_en[j*BANKS_PER_IO +: BANKS_PER_IO]));
    end

endmodule

//--- hdl/io_controller.sv
// per-channel request gate and address generator
// stream word counting, stall handling and read-valid pipeline
module io_controller (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cgra_start_pulse,
    input  logic                           stall,
    input  glb_pkg::io_ctrl_cfg_t          cfg,
    input  glb_pkg::cgra_req_t             cgra_in,
    output logic [glb_pkg::DATA_WIDTH-1:0] rd_data,
    output logic                           rd_data_valid,
    output glb_pkg::bank_req_t             bank_out,
    input  logic [glb_pkg::DATA_WIDTH-1:0] bank_rd_data
);
    import glb_pkg::*;

    logic [CFG_DATA_WIDTH-1:0] word_cnt;
    logic                      words_left;
    logic                      stream_mode;
    logic                      wr_ok;
    logic                      rd_ok;
    logic [GLB_ADDR_WIDTH-1:0] issue_addr;
    logic [1:0]                rd_pipe;

    assign words_left = (word_cnt < cfg.num_words);
    assign stream_mode = (cfg.mode == IO_INSTREAM) || (cfg.mode == IO_OUTSTREAM);

    always_comb begin
        wr_ok = 1'b0;
        rd_ok = 1'b0;
        issue_addr = cgra_in.addr;
        case (cfg.mode)
            IO_INSTREAM: begin
                wr_ok = cgra_in.wr_en && words_left;
                issue_addr = cfg.start_addr + word_cnt[GLB_ADDR_WIDTH-1:0];
            end
            IO_OUTSTREAM: begin
                rd_ok = cgra_in.rd_en && words_left;
                issue_addr = cfg.start_addr + word_cnt[GLB_ADDR_WIDTH-1:0];
            end
            IO_SRAM: begin
                // write wins if both are offered
                wr_ok = cgra_in.wr_en;
                rd_ok = cgra_in.rd_en && !cgra_in.wr_en;
            end
            default: begin
                wr_ok = 1'b0;
                rd_ok = 1'b0;
            end
        endcase
    end

    // stalled requests are dropped
    assign bank_out.wr_en = wr_ok && !stall;
    assign bank_out.rd_en = rd_ok && !stall;
    assign bank_out.addr = issue_addr;
    assign bank_out.data = cgra_in.wr_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            word_cnt <= '0;
        end else if (cgra_start_pulse) begin
            word_cnt <= '0;
        end else if (stream_mode && (bank_out.wr_en || bank_out.rd_en)) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // matches the interconnect return latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_pipe <= 2'b00;
        end else begin
            rd_pipe <= {rd_pipe[0], bank_out.rd_en};
        end
    end

    assign rd_data_valid = rd_pipe[1];
    assign rd_data = bank_rd_data;

    no_wr_and_rd: assert property (@(posedge clk) disable iff (reset)
        !(bank_out.wr_en && bank_out.rd_en));

endmodule

//--- hdl/glb_config_port.sv
// four-phase req/ack adapter for host configuration accesses
module glb_config_port (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               cfg_req,
    input  glb_pkg::cfg_req_t                  cfg_in,
    output logic                               cfg_ack,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0] cfg_rd_data,
    output logic                               cfg_access,
    output glb_pkg::cfg_req_t                  cfg_out,
    input  logic [glb_pkg::CFG_DATA_WIDTH-1:0] reg_rd_data
);
    import glb_pkg::*;

    cfg_state_e state;
    cfg_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            CFG_IDLE: if (cfg_req) state_next = CFG_ACK;
            // ack may drop right away if the host is quick
            CFG_ACK: state_next = cfg_req ? CFG_WAIT_LOW : CFG_IDLE;
            CFG_WAIT_LOW: if (!cfg_req) state_next = CFG_IDLE;
            default: state_next = CFG_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= CFG_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // one strobe per handshake, only from idle
    assign cfg_access = (state == CFG_IDLE) && cfg_req;
    assign cfg_out = cfg_access ? cfg_in : '0;
    assign cfg_ack = (state != CFG_IDLE);

    // capture readback with the access
    always_ff @(posedge clk) begin
        if (cfg_access) begin
            cfg_rd_data <= reg_rd_data;
        end
    end

    // req must have been up in the cycle before ack rose
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(cfg_ack) |-> $past(cfg_req));

    access_single: assert property (@(posedge clk) disable iff (reset)
        cfg_access |=> !cfg_access);

endmodule

//--- common/glb_pkg.sv
// global buffer sizes, register map, request structs and enums
package glb_pkg;

    // sizes
    localparam int NUM_IO = 2;
    localparam int NUM_BANKS = 4;
    localparam int BANKS_PER_IO = NUM_BANKS / NUM_IO;
    localparam int BANK_ADDR_WIDTH = 6;
    localparam int BANK_SEL_WIDTH = 2;
    localparam int BANK_DEPTH = 2 ** BANK_ADDR_WIDTH;
    localparam int GLB_ADDR_WIDTH = BANK_SEL_WIDTH + BANK_ADDR_WIDTH;
    localparam int DATA_WIDTH = 16;
    localparam int CFG_FEATURE_WIDTH = 4;
    localparam int CFG_REG_WIDTH = 4;
    localparam int CFG_DATA_WIDTH = 16;

    // register map
    localparam logic [CFG_FEATURE_WIDTH-1:0] FEATURE_SWITCH = CFG_FEATURE_WIDTH'(NUM_IO);
    localparam logic [CFG_REG_WIDTH-1:0] REG_MODE = CFG_REG_WIDTH'(0);
    localparam logic [CFG_REG_WIDTH-1:0] REG_START_ADDR = CFG_REG_WIDTH'(1);
    localparam logic [CFG_REG_WIDTH-1:0] REG_NUM_WORDS = CFG_REG_WIDTH'(2);
    localparam logic [CFG_REG_WIDTH-1:0] REG_SWITCH_SEL = CFG_REG_WIDTH'(0);

    typedef enum logic [1:0] {
        IO_IDLE      = 2'd0,
        IO_INSTREAM  = 2'd1,
        IO_OUTSTREAM = 2'd2,
        IO_SRAM      = 2'd3
    } io_mode_e;

    typedef struct packed {
        logic                      wr_en;
        logic                      rd_en;
        logic [GLB_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]     wr_data;
    } cgra_req_t;

    typedef struct packed {
        logic                      wr_en;
        logic                      rd_en;
        logic [GLB_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]     data;
    } bank_req_t;

    typedef struct packed {
        io_mode_e                  mode;
        logic [GLB_ADDR_WIDTH-1:0] start_addr;
        logic [CFG_DATA_WIDTH-1:0] num_words;
    } io_ctrl_cfg_t;

    typedef struct packed {
        logic                         wr;
        logic [CFG_FEATURE_WIDTH-1:0] feature;
        logic [CFG_REG_WIDTH-1:0]     reg_addr;
        logic [CFG_DATA_WIDTH-1:0]    data;
    } cfg_req_t;

    typedef enum logic [1:0] {
        CFG_IDLE     = 2'd0,
        CFG_ACK      = 2'd1,
        CFG_WAIT_LOW = 2'd2
    } cfg_state_e;

endpackage
